// ==== Bender.yml ====
package:
  name: alloc_bv

sources:
  # Packages first, then the interface and the RTL
  - verilog/alloc_cfg_pkg.sv
  - verilog/alloc_ctrl_pkg.sv
  - verilog/alloc_slice_if.sv
  - verilog/alloc_bv_slice.sv
  - verilog/alloc_bv_merge.sv
  - verilog/alloc_bv.sv
  - target: test
    files:
      - test/alloc_bv_chk.sv
      - test/alloc_bv_scoreboard.sv
      - test/alloc_bv_tb.sv

// ==== alloc_bv.f ====
verilog/alloc_cfg_pkg.sv
verilog/alloc_ctrl_pkg.sv
verilog/alloc_slice_if.sv
verilog/alloc_bv_slice.sv
verilog/alloc_bv_merge.sv
verilog/alloc_bv.sv
test/alloc_bv_chk.sv
test/alloc_bv_scoreboard.sv
test/alloc_bv_tb.sv

// ==== test/alloc_bv_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module alloc_bv_chk
    import alloc_cfg_pkg::*;
    import alloc_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  slice_state_e state,
    input  logic         alloc_req,
    input  logic         alloc_rdy,
    input  slice_ptr_t   alloc_ptr,
    input  logic         dealloc_err
);

    // Failures seen in this slice, read by the testbench top
    int fail_cnt = 0;

    // Offered pointer stays put until it is taken
    a_rdy_hold: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_rdy && !alloc_req |=> alloc_rdy && $stable(alloc_ptr))
    else begin
        fail_cnt++;
        $error("Slice withdrew or changed its offered pointer before the transfer");
    end

    // Double free report is a single cycle pulse
    a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        dealloc_err |=> !dealloc_err)
    else begin
        fail_cnt++;
        $error("Slice held its double free pulse for two cycles");
    end

    // Clear pass never hands over straight to an offer
    a_init_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_INIT |=> !alloc_rdy)
    else begin
        fail_cnt++;
        $error("Slice offered a pointer during or right after its clear pass");
    end

endmodule

bind alloc_bv_slice alloc_bv_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state),
    .alloc_req   (bus.alloc_req),
    .alloc_rdy   (bus.alloc_rdy),
    .alloc_ptr   (bus.alloc_ptr),
    .dealloc_err (bus.dealloc_err)
);

`default_nettype wire

// ==== test/alloc_bv_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module alloc_bv_scoreboard
    import alloc_cfg_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic init_done,
    input  logic alloc_req,
    input  logic alloc_rdy,
    input  ptr_t alloc_ptr,
    input  logic dealloc_req,
    input  logic dealloc_rdy,
    input  ptr_t dealloc_ptr,
    input  logic dealloc_err,
    input  ptr_t err_ptr,
    output int   err_count
);

    // Model of the allocated set
    logic [MAX_PTRS-1:0] in_use     = '0;
    int                  model_cnt;

    // Error pulse owed on the next edge
    logic                exp_err    = 1'b0;
    ptr_t                exp_ptr    = '0;

    // Edges seen since reset release, saturating
    int                  edges_done = 0;
    logic                rst_seen   = 1'b0;
    logic                exp_init;

    initial begin
        err_count = 0;
        model_cnt = 0;
    end

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        err_count++;
        $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    // ==================================================
    // Sampled at the rising edge, before register updates
    // ==================================================

    always @(posedge clk) begin
        if (rst_seen) begin
            // Clear pass takes exactly NUM_WORDS cycles
            exp_init = (edges_done >= NUM_WORDS);
            if (init_done !== exp_init) begin
                report_value("init_done", init_done, exp_init);
            end
            if (dealloc_rdy !== exp_init) begin
                report_value("dealloc_rdy", dealloc_rdy, exp_init);
            end
            // Nothing to offer before init or with the pool full
            if (alloc_rdy !== 1'b0 && (!exp_init || model_cnt == MAX_PTRS)) begin
                report_value("alloc_rdy", alloc_rdy, 1'b0);
            end
            if (dealloc_err !== exp_err) begin
                report_value("dealloc_err", dealloc_err, exp_err);
            end else if (exp_err && err_ptr !== exp_ptr) begin
                report_value("err_ptr", err_ptr, exp_ptr);
            end
        end
        exp_err = 1'b0;
        if (!rst_n) begin
            rst_seen   = 1'b1;
            edges_done = 0;
            in_use     = '0;
            model_cnt  = 0;
        end else begin
            if (edges_done < NUM_WORDS) begin
                edges_done++;
            end
            if (dealloc_req && dealloc_rdy) begin
                if (in_use[dealloc_ptr]) begin
                    in_use[dealloc_ptr] = 1'b0;
                    model_cnt--;
                end else begin
                    // Freeing a free pointer must be reported
                    exp_err = 1'b1;
                    exp_ptr = dealloc_ptr;
                end
            end
            if (alloc_req && alloc_rdy) begin
                if ($isunknown(alloc_ptr) || in_use[alloc_ptr]) begin
                    err_count++;
                    $display("[ERROR] alloc_ptr 0x%02h handed out while already allocated",
                             alloc_ptr);
                end else begin
                    in_use[alloc_ptr] = 1'b1;
                    model_cnt++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/alloc_bv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alloc_bv_tb
    import alloc_cfg_pkg::*;
();

    // Four phases of at most 20 cycles per pointer, plus slack
    localparam int TIMEOUT_CYCLES = 4 * MAX_PTRS * 20 + 2000;
    localparam int MIX_CYCLES     = 3000;

    logic clk = 1'b0;
    logic rst_n;
    logic init_done;
    logic alloc_req;
    logic alloc_rdy;
    ptr_t alloc_ptr;
    logic dealloc_req;
    logic dealloc_rdy;
    ptr_t dealloc_ptr;
    logic dealloc_err;
    ptr_t err_ptr;

    int   sb_errors;
    int   tb_errors = 0;
    int   cycle_cnt = 0;

    // Pointers currently owned by the stimulus
    ptr_t held[$];

    always #4 clk = ~clk;

    alloc_bv dut (.*);

    alloc_bv_scoreboard u_scoreboard (.*, .err_count(sb_errors));

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ==================================================
    // Stimulus tasks, all entered on a falling edge
    // ==================================================

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic alloc_one(output ptr_t p);
        alloc_req = 1'b1;
        while (!alloc_rdy) @(negedge clk);
        p = alloc_ptr;
        @(negedge clk);
        alloc_req = 1'b0;
    endtask

    task automatic free_one(input ptr_t p);
        dealloc_ptr = p;
        dealloc_req = 1'b1;
        while (!dealloc_rdy) @(negedge clk);
        @(negedge clk);
        dealloc_req = 1'b0;
    endtask

    task automatic shuffle_held();
        int   j;
        ptr_t tmp;
        for (int i = held.size() - 1; i > 0; i--) begin
            j       = $urandom_range(i, 0);
            tmp     = held[i];
            held[i] = held[j];
            held[j] = tmp;
        end
    endtask

    initial begin
        ptr_t p;
        ptr_t freed[$];
        int   idx;
        int   mix_start;
        int   asrt_errors;
        rst_n       = 1'b0;
        alloc_req   = 1'b0;
        dealloc_req = 1'b0;
        dealloc_ptr = '0;
        void'($urandom(32'h1457_cd2b));
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // Init timing is judged by the scoreboard
        while (!init_done) @(negedge clk);
        idle(2);

        // ==================================================
        // Fill the pool, then stay idle while it is full
        // ==================================================
        for (int i = 0; i < MAX_PTRS; i++) begin
            idle($urandom_range(19, 0));
            alloc_one(p);
            held.push_back(p);
        end
        idle(40);

        // Free everything in random order
        shuffle_held();
        while (held.size() > 0) begin
            free_one(held.pop_front());
            idle($urandom_range(3, 0));
        end
        idle(NUM_WORDS);
        // Empty pool, a full search pass has found a clear bit
        if (alloc_rdy !== 1'b1) begin
            tb_errors++;
            $display("[ERROR] alloc_rdy got 0x%0h expected 0x1 with the pool empty",
                     alloc_rdy);
        end
        alloc_one(p);
        free_one(p);
        idle(20);

        // ==================================================
        // Double free, slices sit in hold so freed bits stay clear
        // ==================================================
        for (int i = 0; i < MAX_PTRS / 4; i++) begin
            idle($urandom_range(3, 0));
            alloc_one(p);
            held.push_back(p);
        end
        idle(20);
        while (held.size() > 0) begin
            p = held.pop_front();
            free_one(p);
            freed.push_back(p);
            idle(1);
        end
        foreach (freed[i]) begin
            if (i == 0 || $urandom_range(1, 0) == 1) begin
                free_one(freed[i]);
                idle(1 + $urandom_range(2, 0));
            end
        end
        idle(4);

        // Mixed traffic over both slices
        mix_start = cycle_cnt;
        while (cycle_cnt - mix_start < MIX_CYCLES) begin
            idle($urandom_range(3, 0));
            if (held.size() == 0 || (held.size() < MAX_PTRS && $urandom_range(9, 0) < 6)) begin
                alloc_one(p);
                held.push_back(p);
            end else begin
                idx = $urandom_range(held.size() - 1, 0);
                p   = held[idx];
                held.delete(idx);
                free_one(p);
            end
        end
        idle(4);

        asrt_errors = dut.u_slice_lo.u_chk.fail_cnt + dut.u_slice_hi.u_chk.fail_cnt;
        $display("Error counts: scoreboard %0d, testbench %0d, assertions %0d",
                 sb_errors, tb_errors, asrt_errors);
        if (sb_errors + tb_errors + asrt_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/alloc_bv.sv ====
`timescale 1ns/1ps
`default_nettype none

module alloc_bv
    import alloc_cfg_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    // Status
    output logic init_done,

    // Allocation port
    input  logic alloc_req,
    output logic alloc_rdy,
    output ptr_t alloc_ptr,

    // Deallocation port
    input  logic dealloc_req,
    output logic dealloc_rdy,
    input  ptr_t dealloc_ptr,

    // Double free report
    output logic dealloc_err,
    output ptr_t err_ptr
);

    // Lower half of the pool, pointer top bit zero
    alloc_slice_if lo_if ();

    // Upper half of the pool, pointer top bit one
    alloc_slice_if hi_if ();

    alloc_bv_slice u_slice_lo (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (lo_if.slice)
    );

    alloc_bv_slice u_slice_hi (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (hi_if.slice)
    );

    // Single pool view over both slices
    alloc_bv_merge u_merge (
        .alloc_req   (alloc_req),
        .alloc_rdy   (alloc_rdy),
        .alloc_ptr   (alloc_ptr),
        .dealloc_req (dealloc_req),
        .dealloc_rdy (dealloc_rdy),
        .dealloc_ptr (dealloc_ptr),
        .dealloc_err (dealloc_err),
        .err_ptr     (err_ptr),
        .init_done   (init_done),
        .clk         (clk),
        .rst_n       (rst_n),
        .lo          (lo_if.merge),
        .hi          (hi_if.merge)
    );

endmodule

`default_nettype wire

// ==== verilog/alloc_bv_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module alloc_bv_merge
    import alloc_cfg_pkg::*;
(
    input  logic         alloc_req,
    output logic         alloc_rdy,
    output ptr_t         alloc_ptr,
    input  logic         dealloc_req,
    output logic         dealloc_rdy,
    input  ptr_t         dealloc_ptr,
    output logic         dealloc_err,
    output ptr_t         err_ptr,
    output logic         init_done,
    input  logic         clk,
    input  logic         rst_n,
    alloc_slice_if.merge lo,
    alloc_slice_if.merge hi
);

    // ==================================================
    // Allocation select
    // ==================================================

    // Round-robin bit, high favours the upper slice
    logic rr_hi;

    // Choice presented last cycle and not yet taken
    logic pick_vld;
    logic pick_hi;

    logic sel_hi;
    logic alloc_fire;

    // A presented pointer stays put until it is consumed
    always_comb begin
        if (pick_vld) begin
            sel_hi = pick_hi;
        end else if (lo.alloc_rdy && hi.alloc_rdy) begin
            sel_hi = rr_hi;
        end else begin
            sel_hi = hi.alloc_rdy;
        end
    end

    assign alloc_rdy  = lo.alloc_rdy | hi.alloc_rdy;
    assign alloc_fire = alloc_req & alloc_rdy;
    assign alloc_ptr  = sel_hi ? {1'b1, hi.alloc_ptr} : {1'b0, lo.alloc_ptr};

    // Only the chosen slice sees the request
    assign lo.alloc_req = alloc_req & ~sel_hi;
    assign hi.alloc_req = alloc_req & sel_hi;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_hi    <= 1'b0;
            pick_vld <= 1'b0;
        end else begin
            if (alloc_fire) begin
                rr_hi <= ~rr_hi;
            end
            pick_vld <= alloc_rdy & ~alloc_req;
        end
    end

    always_ff @(posedge clk) begin
        pick_hi <= sel_hi;
    end

    // ==================================================
    // Deallocation steering
    // ==================================================

    logic dsel_hi;

    assign dsel_hi = dealloc_ptr[PTR_WID-1];

    assign lo.dealloc_req = dealloc_req & ~dsel_hi;
    assign hi.dealloc_req = dealloc_req & dsel_hi;
    assign lo.dealloc_ptr = dealloc_ptr[SLICE_PTR_WID-1:0];
    assign hi.dealloc_ptr = dealloc_ptr[SLICE_PTR_WID-1:0];

    assign dealloc_rdy = dsel_hi ? hi.dealloc_rdy : lo.dealloc_rdy;

    // ==================================================
    // Error merge and status
    // ==================================================

    // One slice accepts per edge, so pulses never overlap
    assign dealloc_err = lo.dealloc_err | hi.dealloc_err;
    assign err_ptr     = hi.dealloc_err ? {1'b1, hi.err_ptr} : {1'b0, lo.err_ptr};

    assign init_done = lo.init_done & hi.init_done;

endmodule

`default_nettype wire

// ==== verilog/alloc_bv_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module alloc_bv_slice
    import alloc_cfg_pkg::*;
    import alloc_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    alloc_slice_if.slice bus
);

    // ==================================================
    // Storage and control state
    // ==================================================

    // One bit per pointer, set while allocated or reserved
    logic [WORD_WID-1:0]    words     [NUM_WORDS];
    logic [WORD_WID-1:0]    words_nxt [NUM_WORDS];

    slice_state_e           state;

    // Shared by the clear pass and the rotating search
    word_idx_t              word_idx;

    // Search result for the current word
    logic                   hit;
    logic [BIT_IDX_WID-1:0] hit_bit;
    logic                   scan_hit;

    // Deallocation decode
    logic                   dealloc_fire;
    word_idx_t              dealloc_word;
    logic [BIT_IDX_WID-1:0] dealloc_bit;
    logic                   dealloc_was_set;

    logic                   alloc_fire;

    // ==================================================
    // Handshakes and status
    // ==================================================

    assign alloc_fire   = bus.alloc_req & bus.alloc_rdy;
    assign dealloc_fire = bus.dealloc_req & bus.dealloc_rdy;

    assign bus.init_done   = (state != ST_INIT);
    assign bus.dealloc_rdy = (state != ST_INIT);

    // Reserved pointer is on offer for the whole hold
    assign bus.alloc_rdy   = (state == ST_HOLD);

    // Upper bits pick the word, lower bits the bit in it
    assign {dealloc_word, dealloc_bit} = bus.dealloc_ptr;
    assign dealloc_was_set = words[dealloc_word][dealloc_bit];

    // ==================================================
    // Free search
    // ==================================================

    // Priority pick of the lowest clear bit
    always_comb begin
        hit     = 1'b0;
        hit_bit = '0;
        // Walk downwards so lower bits overwrite higher ones
        for (int b = WORD_WID - 1; b >= 0; b--) begin
            if (!words[word_idx][b]) begin
                hit     = 1'b1;
                hit_bit = BIT_IDX_WID'(b);
            end
        end
    end

    assign scan_hit = (state == ST_SCAN) & hit;

    // ==================================================
    // Vector update
    // ==================================================

    always_comb begin
        for (int w = 0; w < NUM_WORDS; w++) begin
            words_nxt[w] = words[w];
            if (state == ST_INIT) begin
                // Clear pass, one word per cycle
                if (word_idx == word_idx_t'(w)) begin
                    words_nxt[w] = '0;
                end
            end else begin
                if (dealloc_fire && dealloc_word == word_idx_t'(w)) begin
                    words_nxt[w][dealloc_bit] = 1'b0;
                end
                // Reservation applied last so a fresh pick is never lost
                if (scan_hit && word_idx == word_idx_t'(w)) begin
                    words_nxt[w][hit_bit] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WORDS; w++) begin
            words[w] <= words_nxt[w];
        end
    end

    // ==================================================
    // Control FSM
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_INIT;
            word_idx <= '0;
        end else begin
            case (state)
                ST_INIT: begin
                    word_idx <= word_idx + 1'b1;
                    // Last word cleared, index wraps back to zero
                    if (word_idx == word_idx_t'(NUM_WORDS - 1)) begin
                        state <= ST_SCAN;
                    end
                end
                ST_SCAN: begin
                    // Always step on so the next search starts elsewhere
                    word_idx <= word_idx + 1'b1;
                    if (hit) begin
                        state <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (alloc_fire) begin
                        state <= ST_SCAN;
                    end
                end
                default: begin
                    state <= ST_INIT;
                end
            endcase
        end
    end

    // Pointer captured together with its reservation
    always_ff @(posedge clk) begin
        if (scan_hit) begin
            bus.alloc_ptr <= {word_idx, hit_bit};
        end
    end

    // ==================================================
    // Double free report
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.dealloc_err <= 1'b0;
        end else begin
            bus.dealloc_err <= dealloc_fire & ~dealloc_was_set;
        end
    end

    always_ff @(posedge clk) begin
        if (dealloc_fire) begin
            bus.err_ptr <= bus.dealloc_ptr;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alloc_cfg_pkg.sv ====
`default_nettype none

package alloc_cfg_pkg;

    // ==================================================
    // Pool geometry
    // ==================================================

    // Entries in the whole buffer pool
    localparam int MAX_PTRS      = 256;
    localparam int PTR_WID       = $clog2(MAX_PTRS);

    // Top pointer bit picks one of the two slices
    localparam int SLICE_PTR_WID = PTR_WID - 1;

    // Search step size, one vector word per cycle
    localparam int WORD_WID      = 16;
    localparam int BIT_IDX_WID   = $clog2(WORD_WID);
    localparam int NUM_WORDS     = (MAX_PTRS / 2) / WORD_WID;

    // ==================================================
    // Pointer types
    // ==================================================

    typedef logic [PTR_WID-1:0]            ptr_t;
    typedef logic [SLICE_PTR_WID-1:0]      slice_ptr_t;
    typedef logic [$clog2(NUM_WORDS)-1:0]  word_idx_t;

endpackage

`default_nettype wire

// ==== verilog/alloc_ctrl_pkg.sv ====
`default_nettype none

package alloc_ctrl_pkg;

    // Slice control states
    // ST_INIT clears the vector one word per cycle
    // ST_SCAN walks the words looking for a clear bit
    // ST_HOLD presents a reserved pointer until taken
    typedef enum logic [1:0] {
        ST_INIT = 2'd0,
        ST_SCAN = 2'd1,
        ST_HOLD = 2'd2
    } slice_state_e;

endpackage

`default_nettype wire

// ==== verilog/alloc_slice_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface alloc_slice_if
    import alloc_cfg_pkg::*;
#(
    parameter type ptr_type = slice_ptr_t
) ();

    // Slice status
    logic    init_done;

    // Allocation channel
    logic    alloc_req;
    logic    alloc_rdy;
    ptr_type alloc_ptr;

    // Deallocation channel
    logic    dealloc_req;
    logic    dealloc_rdy;
    ptr_type dealloc_ptr;

    // Double free report, one cycle pulse
    logic    dealloc_err;
    ptr_type err_ptr;

    modport slice (
        input  alloc_req, dealloc_req, dealloc_ptr,
        output init_done, alloc_rdy, alloc_ptr,
        output dealloc_rdy, dealloc_err, err_ptr
    );

    modport merge (
        output alloc_req, dealloc_req, dealloc_ptr,
        input  init_done, alloc_rdy, alloc_ptr,
        input  dealloc_rdy, dealloc_err, err_ptr
    );

endinterface

`default_nettype wire
